/* hw/loader_pkg.sv */
`default_nettype none

package loader_pkg;

  // datapath widths
  localparam int WORD_W = 32;
  localparam int CMD_W  = 36;
  localparam int SRC_AW = 10;  // backing memory, 1024 words
  localparam int TGT_AW = 8;   // IM and DM, 256 words each
  localparam int SIZE_W = 16;

  // command queue
  localparam int CMD_DEPTH = 4;  // also the host's starting credit count
  localparam int QPTR_W    = $clog2(CMD_DEPTH);

  // command word fields
  localparam int CMD_CLEAR_BIT  = 35;
  localparam int CMD_SELECT_BIT = 33;  // 0 IM, 1 DM
  localparam int START_LSB      = 16;  // start address in 31:16
  localparam int SIZE_LSB       = 0;   // size in 15:0

  // bits 34 and 32 are reserved, enable and direction follow from the op

  typedef enum logic {
    OP_LOAD,
    OP_CLEAR
  } mem_op_e;

  typedef enum logic {
    TGT_IM,
    TGT_DM
  } target_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COPY,   // one issue per cycle
    ST_DRAIN   // last write leaves the pipeline
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one access port of a single-ported memory
interface mem_port_if #(
  parameter int AW = loader_pkg::TGT_AW
);
  import loader_pkg::*;

  logic              en;
  logic              we;
  logic [AW-1:0]     addr;
  logic [WORD_W-1:0] wdata;
  logic [WORD_W-1:0] rdata;  // valid one cycle after a read

  modport ctrl (
    output en,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport mem (
    input  en,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* hw/cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_queue (
  input  logic                       clock,
  input  logic                       ir_rst,
  input  logic                       push,
  input  logic [loader_pkg::CMD_W-1:0] push_data,
  input  logic                       pop,
  output logic [loader_pkg::CMD_W-1:0] head,
  output logic                       pending,
  output logic                       cmd_credit
);
  import loader_pkg::*;

  logic [CMD_W-1:0]  entries [CMD_DEPTH];
  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QPTR_W:0]   count;  // one extra bit to hold CMD_DEPTH

  // storage, written on push only
  always_ff @(posedge clock) begin
    if (push) begin
      entries[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head    = entries[rd_ptr];
  assign pending = (count != '0);

  // credit goes back to the host as the slot frees up
  assign cmd_credit = pop;

endmodule

`default_nettype wire

/* hw/mem_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_controller (
  input  logic                         clock,
  input  logic                         ir_rst,
  input  logic                         pending,
  input  logic [loader_pkg::CMD_W-1:0] head,
  output logic                         pop,
  mem_port_if.ctrl                     src_port,
  mem_port_if.ctrl                     im_port,
  mem_port_if.ctrl                     dm_port,
  output logic                         done,
  output loader_pkg::target_e          done_target
);
  import loader_pkg::*;

  ctrl_state_e state;

  // decoded head of queue
  mem_op_e           cmd_op;
  target_e           cmd_tgt;
  logic [SIZE_W-1:0] cmd_size;

  // latched command
  mem_op_e op_q;
  target_e tgt_q;

  // issue side
  logic [SRC_AW-1:0] src_addr;
  logic [TGT_AW-1:0] tgt_addr;
  logic [SIZE_W-1:0] remaining;

  // write side, one stage behind the issue
  logic              wr_valid;
  logic [TGT_AW-1:0] wr_addr;
  logic [WORD_W-1:0] wr_data;

  assign cmd_op   = head[CMD_CLEAR_BIT] ? OP_CLEAR : OP_LOAD;
  assign cmd_tgt  = head[CMD_SELECT_BIT] ? TGT_DM : TGT_IM;
  assign cmd_size = head[SIZE_LSB +: SIZE_W];

  assign pop = (state == ST_IDLE) && pending;

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      state       <= ST_IDLE;
      wr_valid    <= 1'b0;
      done        <= 1'b0;
      done_target <= TGT_IM;
    end else begin
      done     <= 1'b0;
      wr_valid <= (state == ST_COPY);  // every issue becomes a write next cycle
      case (state)
        ST_IDLE: begin
          if (pop) begin
            if (cmd_size == '0) begin
              // nothing to move, finish right away
              done        <= 1'b1;
              done_target <= cmd_tgt;
            end else begin
              state <= ST_COPY;
            end
          end
        end
        ST_COPY: begin
          if (remaining == SIZE_W'(1)) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          state       <= ST_IDLE;
          done        <= 1'b1;
          done_target <= tgt_q;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // counters and latched fields
  always_ff @(posedge clock) begin
    if (pop) begin
      op_q      <= cmd_op;
      tgt_q     <= cmd_tgt;
      src_addr  <= head[START_LSB +: SRC_AW];  // low bits of start field
      tgt_addr  <= '0;
      remaining <= cmd_size;
    end else if (state == ST_COPY) begin
      src_addr  <= src_addr + 1'b1;
      tgt_addr  <= tgt_addr + 1'b1;  // wraps inside the target
      remaining <= remaining - 1'b1;
    end
    wr_addr <= tgt_addr;
  end

  // source read, load only
  assign src_port.en    = (state == ST_COPY) && (op_q == OP_LOAD);
  assign src_port.we    = 1'b0;
  assign src_port.addr  = src_addr;
  assign src_port.wdata = '0;

  // clear writes zeros, load forwards the source word
  assign wr_data = (op_q == OP_CLEAR) ? '0 : src_port.rdata;

  // only the selected target sees enable and write
  assign im_port.en    = wr_valid && (tgt_q == TGT_IM);
  assign im_port.we    = wr_valid && (tgt_q == TGT_IM);
  assign im_port.addr  = wr_addr;
  assign im_port.wdata = wr_data;

  assign dm_port.en    = wr_valid && (tgt_q == TGT_DM);
  assign dm_port.we    = wr_valid && (tgt_q == TGT_DM);
  assign dm_port.addr  = wr_addr;
  assign dm_port.wdata = wr_data;

endmodule

`default_nettype wire

/* hw/backing_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module backing_mem (
  input  logic                          clock,
  input  logic                          host_we,
  input  logic [loader_pkg::SRC_AW-1:0] host_addr,
  input  logic [loader_pkg::WORD_W-1:0] host_wdata,
  mem_port_if.mem                       port
);
  import loader_pkg::*;

  localparam int SRC_WORDS = 1 << SRC_AW;

  logic [WORD_W-1:0] mem [SRC_WORDS];
  logic              rd_en;

  // the controller side only reads
  assign rd_en = port.en && !port.we;

  // host fills the memory before any command runs
  always_ff @(posedge clock) begin
    if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
  end

  // registered read, one cycle of latency
  always_ff @(posedge clock) begin
    if (rd_en) begin
      port.rdata <= mem[port.addr];
    end
  end

endmodule

`default_nettype wire

/* hw/local_mem.sv */
`timescale 1ns/1ps
`default_nettype none

// IM or DM
module local_mem (
  input  logic                          clock,
  mem_port_if.mem                       port,
  input  logic [loader_pkg::TGT_AW-1:0] rd_addr,
  output logic [loader_pkg::WORD_W-1:0] rd_data
);
  import loader_pkg::*;

  localparam int TGT_WORDS = 1 << TGT_AW;

  logic [WORD_W-1:0] mem [TGT_WORDS];

  always_ff @(posedge clock) begin
    if (port.en && port.we) begin
      mem[port.addr] <= port.wdata;
    end
  end

  always_ff @(posedge clock) begin
    rd_data <= mem[rd_addr];  // host read-back
  end

endmodule

`default_nettype wire

/* hw/loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_top (
  input  logic                          clock,
  input  logic                          ir_rst,
  // command channel, credit based
  input  logic                          cmd_valid,
  input  logic [loader_pkg::CMD_W-1:0]  cmd_word,
  output logic                          cmd_credit,
  // backing memory fill
  input  logic                          host_we,
  input  logic [loader_pkg::SRC_AW-1:0] host_addr,
  input  logic [loader_pkg::WORD_W-1:0] host_wdata,
  // read-back
  input  logic [loader_pkg::TGT_AW-1:0] im_rd_addr,
  output logic [loader_pkg::WORD_W-1:0] im_rd_data,
  input  logic [loader_pkg::TGT_AW-1:0] dm_rd_addr,
  output logic [loader_pkg::WORD_W-1:0] dm_rd_data,
  output logic                          done,
  output loader_pkg::target_e           done_target
);
  import loader_pkg::*;

  logic             pending;
  logic             pop;
  logic [CMD_W-1:0] head;

  mem_port_if #(.AW(SRC_AW)) src_port ();
  mem_port_if #(.AW(TGT_AW)) im_port ();
  mem_port_if #(.AW(TGT_AW)) dm_port ();

  cmd_queue u_cmd_queue (
    .clock      (clock),
    .ir_rst     (ir_rst),
    .push       (cmd_valid),
    .push_data  (cmd_word),
    .pop        (pop),
    .head       (head),
    .pending    (pending),
    .cmd_credit (cmd_credit)
  );

  mem_controller u_mem_controller (
    .clock       (clock),
    .ir_rst      (ir_rst),
    .pending     (pending),
    .head        (head),
    .pop         (pop),
    .src_port    (src_port.ctrl),
    .im_port     (im_port.ctrl),
    .dm_port     (dm_port.ctrl),
    .done        (done),
    .done_target (done_target)
  );

  backing_mem u_backing_mem (
    .clock      (clock),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .port       (src_port.mem)
  );

  local_mem im_mem (
    .clock   (clock),
    .port    (im_port.mem),
    .rd_addr (im_rd_addr),
    .rd_data (im_rd_data)
  );

  local_mem dm_mem (
    .clock   (clock),
    .port    (dm_port.mem),
    .rd_addr (dm_rd_addr),
    .rd_data (dm_rd_data)
  );

endmodule

`default_nettype wire

/* bench/loader_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_asserts (
  input logic                     clock,
  input logic                     ir_rst,
  input logic                     pop,
  input logic                     done,
  input loader_pkg::ctrl_state_e  state,
  input logic                     im_we,
  input logic                     dm_we
);
  import loader_pkg::*;

  // a popped command either starts a transfer or finishes at once
  property pop_starts_transfer;
    @(posedge clock) disable iff (ir_rst)
      pop |=> (state == ST_COPY) || done;
  endproperty

  // write pipeline is empty again once the FSM is idle
  property writes_only_in_transfer;
    @(posedge clock) disable iff (ir_rst)
      (im_we || dm_we) |-> (state != ST_IDLE);
  endproperty

  property done_single_cycle;
    @(posedge clock) disable iff (ir_rst)
      done |=> !done;
  endproperty

  a_pop_start: assert property (pop_starts_transfer)
    else $error("popped command neither started a transfer nor finished");
  a_write_busy: assert property (writes_only_in_transfer)
    else $error("target written while the controller was idle");
  a_done_pulse: assert property (done_single_cycle)
    else $error("done held high for more than one cycle");

endmodule

bind mem_controller loader_asserts u_asserts (
  .clock   (clock),
  .ir_rst  (ir_rst),
  .pop     (pop),
  .done    (done),
  .state   (state),
  .im_we   (im_port.we),
  .dm_we   (dm_port.we)
);

`default_nettype wire

/* bench/loader_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_tb;
  import loader_pkg::*;

  localparam int PERIOD    = 40;
  localparam int SRC_WORDS = 1 << SRC_AW;
  localparam int TGT_WORDS = 1 << TGT_AW;
  localparam int NUM_CMDS  = 11;
  localparam logic [31:0] SEED = 32'h171f7b44;

  logic              clock;
  logic              ir_rst;
  logic              cmd_valid;
  logic [CMD_W-1:0]  cmd_word;
  logic              cmd_credit;
  logic              host_we;
  logic [SRC_AW-1:0] host_addr;
  logic [WORD_W-1:0] host_wdata;
  logic [TGT_AW-1:0] im_rd_addr;
  logic [WORD_W-1:0] im_rd_data;
  logic [TGT_AW-1:0] dm_rd_addr;
  logic [WORD_W-1:0] dm_rd_data;
  logic              done;
  target_e           done_target;

  // command table with the points where all of IM and DM are read back
  logic [CMD_W-1:0]  cmd_table [NUM_CMDS];
  bit                check_table [NUM_CMDS];
  bit                table_ready;

  // reference model
  logic [WORD_W-1:0] src_model [SRC_WORDS];
  logic [WORD_W-1:0] im_model [TGT_WORDS];
  logic [WORD_W-1:0] dm_model [TGT_WORDS];
  target_e           exp_targets [$];

  int credits;
  int credit_pulses;
  int pushed;
  int dones;

  loader_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  task automatic stop_with_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic [CMD_W-1:0] cmd_word_of(input bit clr, input bit dm,
      input bit [1:0] rsv, input logic [15:0] start, input logic [15:0] size);
    return {clr, rsv[1], dm, rsv[0], start, size};  // 35 clr, 33 select
  endfunction

  task automatic build_table();
    cmd_table[0]  = cmd_word_of(1, 0, 2'b00, 16'h0000, 16'd256);  // clear all IM
    cmd_table[1]  = cmd_word_of(1, 1, 2'b00, 16'h0000, 16'd256);  // clear all DM
    cmd_table[2]  = cmd_word_of(0, 0, 2'b00, 16'hfc10, 16'd40);   // upper start bits dropped
    cmd_table[3]  = cmd_word_of(0, 1, 2'b00, 16'h0200, 16'd64);
    cmd_table[4]  = cmd_word_of(1, 0, 2'b00, 16'h03ff, 16'd10);   // part of the IM block
    cmd_table[5]  = cmd_word_of(0, 1, 2'b00, 16'h03f0, 16'd30);   // source wraps
    cmd_table[6]  = cmd_word_of(0, 0, 2'b00, 16'h0100, 16'd300);  // target wraps
    cmd_table[7]  = cmd_word_of(1, 1, 2'b00, 16'h0000, 16'd5);
    cmd_table[8]  = cmd_word_of(0, 0, 2'b00, 16'h0050, 16'd20);
    cmd_table[9]  = cmd_word_of(0, 1, 2'b11, 16'h0123, 16'd0);    // empty with reserved bits set
    cmd_table[10] = cmd_word_of(1, 0, 2'b11, 16'h0040, 16'd0);
    check_table = '{0, 1, 1, 1, 1, 0, 0, 0, 1, 1, 1};
  endtask

  function automatic int budget_cycles();
    int total;
    total = 50 + SRC_WORDS + TGT_WORDS + 4;  // fill and the final read-back
    for (int i = 0; i < NUM_CMDS; i++) begin
      total += {16'd0, cmd_table[i][SIZE_W-1:0]} + 4;
      if (check_table[i]) begin
        total += TGT_WORDS + 4;  // read-back pass
      end
    end
    return total;
  endfunction

  // one falling edge, then sample what the DUT did in the cycle before
  task automatic next_cycle();
    target_e want;
    @(negedge clock);
    if (cmd_credit) begin
      credit_pulses++;
      credits++;
      assert (credits <= CMD_DEPTH)
        else stop_with_error("credit returned with no command in the queue");
    end
    if (done) begin
      assert (exp_targets.size() > 0)
        else stop_with_error("done pulsed with no command outstanding");
      want = exp_targets.pop_front();
      assert (done_target == want)
        else stop_with_error($sformatf("done_target %s, expected %s",
                                       done_target.name(), want.name()));
      dones++;
    end
  endtask

  task automatic apply_to_model(input logic [CMD_W-1:0] cmd);
    int                size;
    logic [TGT_AW-1:0] t_idx;
    logic [SRC_AW-1:0] s_idx;
    logic [WORD_W-1:0] value;
    size  = {16'd0, cmd[15:0]};
    t_idx = '0;
    s_idx = cmd[16 +: SRC_AW];
    for (int i = 0; i < size; i++) begin
      value = cmd[35] ? '0 : src_model[s_idx];
      if (cmd[33]) begin
        dm_model[t_idx] = value;
      end else begin
        im_model[t_idx] = value;
      end
      t_idx = t_idx + 1'b1;  // both wrap by width
      s_idx = s_idx + 1'b1;
    end
  endtask

  task automatic send_command(input logic [CMD_W-1:0] cmd);
    credits--;
    cmd_valid = 1'b1;
    cmd_word  = cmd;
    exp_targets.push_back(cmd[33] ? TGT_DM : TGT_IM);
    apply_to_model(cmd);
    pushed++;
  endtask

  task automatic compare_memories();
    logic [TGT_AW-1:0] addr;
    while (dones < pushed) next_cycle();  // watchdog bounds this wait
    assert (credit_pulses == pushed)
      else stop_with_error($sformatf("%0d pushed, %0d credits back",
                                     pushed, credit_pulses));
    for (int a = 0; a < TGT_WORDS; a++) begin
      addr       = a[TGT_AW-1:0];
      im_rd_addr = addr;
      dm_rd_addr = addr;
      next_cycle();
      assert (im_rd_data === im_model[addr])
        else stop_with_error($sformatf("IM[%0d] = %h, expected %h",
                                       addr, im_rd_data, im_model[addr]));
      assert (dm_rd_data === dm_model[addr])
        else stop_with_error($sformatf("DM[%0d] = %h, expected %h",
                                       addr, dm_rd_data, dm_model[addr]));
    end
  endtask

  initial begin
    int limit;
    wait (table_ready);
    limit = budget_cycles();
    repeat (limit) @(posedge clock);
    $display("timeout: the command table did not finish within %0d cycles", limit);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    ir_rst        = 1'b1;
    cmd_valid     = 1'b0;
    cmd_word      = '0;
    host_we       = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    im_rd_addr    = '0;
    dm_rd_addr    = '0;
    credits       = CMD_DEPTH;
    credit_pulses = 0;
    pushed        = 0;
    dones         = 0;
    build_table();
    table_ready = 1'b1;

    repeat (2) @(posedge clock);
    @(negedge clock);
    ir_rst = 1'b0;

    // fill the backing memory while the DUT stays quiet
    for (int a = 0; a < SRC_WORDS; a++) begin
      next_cycle();
      assert (!done && !cmd_credit)
        else stop_with_error("done or cmd_credit high before any command");
      host_we    = 1'b1;
      host_addr  = a[SRC_AW-1:0];
      host_wdata = $urandom();
      src_model[host_addr] = host_wdata;
    end
    next_cycle();
    host_we = 1'b0;

    for (int i = 0; i < NUM_CMDS; i++) begin
      while (credits == 0) begin
        cmd_valid = 1'b0;
        next_cycle();
      end
      send_command(cmd_table[i]);
      next_cycle();
      if (check_table[i]) begin
        cmd_valid = 1'b0;
        compare_memories();
      end
    end
    cmd_valid = 1'b0;

    compare_memories();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/loader_pkg.sv
hw/mem_port_if.sv
hw/cmd_queue.sv
hw/mem_controller.sv
hw/backing_mem.sv
hw/local_mem.sv
hw/loader_top.sv
bench/loader_asserts.sv
bench/loader_tb.sv

/* Makefile */
# Verilator build and run of the memory loader testbench

TOP := loader_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run, fails unless the run passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f verilog.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	if echo "$$out" | grep -q "STATUS: PASS"; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf obj_dir
